//--- src/spi_regs_cfg.svh
// build-wide sizes for the register bridge
// data width stays at 8 since every register travels in one SPI byte
// the address width must cover the register count
`ifndef SPI_REGS_CFG_SVH
`define SPI_REGS_CFG_SVH

// register payload width in bits
`define SPI_REGS_DATA_W 8
// register address width, also the low nibble of the SPI command byte
`define SPI_REGS_ADDR_W 4
// number of registers held by the bank
`define SPI_REGS_COUNT 16
// byte shifted back to the MCU while it sends a command byte
`define SPI_REGS_IDLE_REPLY 8'h01

`endif

//--- src/spi_regs_pkg.sv
// shared request, response and AXI4-Lite channel types
// field widths follow the cfg header, AXI widths are fixed at 32 bits
`default_nettype none

`include "spi_regs_cfg.svh"

package spi_regs_pkg;

    // one register access, served in the cycle it is granted
    typedef struct packed {
        logic                        valid;
        logic                        write;
        logic [`SPI_REGS_ADDR_W-1:0] addr;
        logic [`SPI_REGS_DATA_W-1:0] wdata;
    } reg_req_t;

    // read result, valid exactly one cycle after the granted read request
    typedef struct packed {
        logic                        valid;
        logic [`SPI_REGS_DATA_W-1:0] rdata;
    } reg_rsp_t;

    // everything the AXI4-Lite master drives
    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_req_t;

    // everything the AXI4-Lite slave drives back
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- src/spi_byte_slave.sv
// SPI mode 0 byte slave, oversampled by clk through a two-flop synchronizer
// spi_clk period must be at least 8 clk cycles; spi_miso is driven low while spi_ss is high
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module spi_byte_slave (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_clk,
    input  logic       spi_ss,
    input  logic       spi_mosi,
    input  logic [7:0] tx_byte,
    output logic       spi_miso,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_start
);
    localparam logic [7:0] idle_reply = `SPI_REGS_IDLE_REPLY;

    logic [2:0] sclk_sr;
    logic [2:0] ss_sr;
    logic [1:0] mosi_sr;
    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [6:0] tx_shift;
    logic       byte_done;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       ss_active;

    // edges come from the top two stages, so the first stage only synchronizes
    assign sclk_rise   = (sclk_sr[2:1] == 2'b01);
    assign sclk_fall   = (sclk_sr[2:1] == 2'b10);
    assign ss_active   = ~ss_sr[1];
    assign frame_start = (ss_sr[2:1] == 2'b10);

    // spi_ss resets to inactive so no frame start shows up out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sr <= 3'b000;
            ss_sr   <= 3'b111;
            mosi_sr <= 2'b00;
        end else begin
            sclk_sr <= {sclk_sr[1:0], spi_clk};
            ss_sr   <= {ss_sr[1:0], spi_ss};
            mosi_sr <= {mosi_sr[0], spi_mosi};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= 3'd0;
            byte_done <= 1'b0;
            rx_valid  <= 1'b0;
            spi_miso  <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            // one extra stage so rx_byte is captured together with the pulse
            rx_valid  <= byte_done;
            if (!ss_active) begin
                bit_cnt  <= 3'd0;
                spi_miso <= 1'b0;
            end else if (frame_start) begin
                // no falling edge precedes the first bit of a frame in mode 0
                spi_miso <= idle_reply[7];
            end else if (sclk_rise) begin
                bit_cnt   <= bit_cnt + 3'd1;
                byte_done <= (bit_cnt == 3'd7);
            end else if (sclk_fall) begin
                // bit_cnt wrapped to zero means the next byte starts here
                spi_miso <= (bit_cnt == 3'd0) ? tx_byte[7] : tx_shift[6];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ss_active && sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sr[1]};
        end
        if (byte_done) begin
            rx_byte <= rx_shift;
        end
        // tx_shift holds the bits still to go after the one on spi_miso
        if (frame_start) begin
            tx_shift <= idle_reply[6:0];
        end else if (ss_active && sclk_fall) begin
            tx_shift <= (bit_cnt == 3'd0) ? tx_byte[6:0] : {tx_shift[5:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- src/spi_cmd_ctrl.sv
// parses two-byte SPI frames into register requests
// bytes past the second in a frame are dropped until the next frame start
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module spi_cmd_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [7:0]             rx_byte,
    input  logic                   rx_valid,
    input  logic                   frame_start,
    input  spi_regs_pkg::reg_rsp_t spi_rsp,
    output logic [7:0]             tx_byte,
    output spi_regs_pkg::reg_req_t spi_req
);
    typedef enum logic {
        st_cmd,
        st_data
    } state_t;

    state_t                      state;
    logic                        frame_done;
    logic                        cmd_write;
    logic [`SPI_REGS_ADDR_W-1:0] cmd_addr;
    logic [7:0]                  tx_q;

    // read data goes straight through in the response cycle, then tx_q holds it
    assign tx_byte = spi_rsp.valid ? spi_rsp.rdata : tx_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_cmd;
            frame_done <= 1'b0;
            spi_req    <= '0;
            tx_q       <= `SPI_REGS_IDLE_REPLY;
        end else begin
            // requests last a single cycle, the bank always grants SPI
            spi_req.valid <= 1'b0;
            if (frame_start) begin
                state      <= st_cmd;
                frame_done <= 1'b0;
                tx_q       <= `SPI_REGS_IDLE_REPLY;
            end else if (rx_valid && !frame_done) begin
                case (state)
                    st_cmd: begin
                        state <= st_data;
                        // a read goes out now so the data is ready for byte 2
                        if (!rx_byte[7]) begin
                            spi_req.valid <= 1'b1;
                            spi_req.write <= 1'b0;
                            spi_req.addr  <= rx_byte[`SPI_REGS_ADDR_W-1:0];
                        end
                    end
                    st_data: begin
                        state      <= st_cmd;
                        frame_done <= 1'b1;
                        tx_q       <= `SPI_REGS_IDLE_REPLY;
                        if (cmd_write) begin
                            spi_req.valid <= 1'b1;
                            spi_req.write <= 1'b1;
                            spi_req.addr  <= cmd_addr;
                            spi_req.wdata <= rx_byte;
                        end
                    end
                    default: state <= st_cmd;
                endcase
            end else if (spi_rsp.valid) begin
                tx_q <= spi_rsp.rdata;
            end
        end
    end

    // the command is kept for the data byte of a write
    always_ff @(posedge clk) begin
        if (rx_valid && state == st_cmd && !frame_done) begin
            cmd_write <= rx_byte[7];
            cmd_addr  <= rx_byte[`SPI_REGS_ADDR_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- src/axil_reg_port.sv
// AXI4-Lite slave into the register bank, one transaction at a time, always OKAY
// only byte lane 0 is written; a write with wstrb[0] clear completes without effect
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module axil_reg_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  spi_regs_pkg::axil_req_t axil_req,
    input  spi_regs_pkg::reg_rsp_t  axi_rsp,
    input  logic                    axi_grant,
    output spi_regs_pkg::axil_rsp_t axil_rsp,
    output spi_regs_pkg::reg_req_t  axi_req
);
    typedef enum logic [2:0] {
        st_idle,
        st_wr_req,
        st_wr_resp,
        st_rd_req,
        st_rd_wait,
        st_rd_resp
    } state_t;

    state_t                      state;
    logic                        aw_ready_q;
    logic                        w_ready_q;
    logic                        ar_ready_q;
    logic                        aw_full;
    logic                        w_full;
    logic                        ar_full;
    logic [`SPI_REGS_ADDR_W-1:0] aw_addr_q;
    logic [`SPI_REGS_ADDR_W-1:0] ar_addr_q;
    logic [`SPI_REGS_DATA_W-1:0] w_data_q;
    logic                        w_lane0_q;
    logic [`SPI_REGS_DATA_W-1:0] r_data_q;
    logic                        aw_hs;
    logic                        w_hs;
    logic                        ar_hs;

    assign aw_hs = axil_req.awvalid && aw_ready_q;
    assign w_hs  = axil_req.wvalid && w_ready_q;
    assign ar_hs = axil_req.arvalid && ar_ready_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            aw_ready_q <= 1'b0;
            w_ready_q  <= 1'b0;
            ar_ready_q <= 1'b0;
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            ar_full    <= 1'b0;
        end else begin
            // ready is a one-cycle answer to valid and stays low while the slot is held
            aw_ready_q <= axil_req.awvalid && !aw_ready_q && !aw_full;
            w_ready_q  <= axil_req.wvalid && !w_ready_q && !w_full;
            ar_ready_q <= axil_req.arvalid && !ar_ready_q && !ar_full;
            if (aw_hs) aw_full <= 1'b1;
            if (w_hs) w_full <= 1'b1;
            if (ar_hs) ar_full <= 1'b1;
            case (state)
                // a complete write wins over a pending read
                st_idle: begin
                    if (aw_full && w_full) begin
                        state <= w_lane0_q ? st_wr_req : st_wr_resp;
                    end else if (ar_full) begin
                        state <= st_rd_req;
                    end
                end
                st_wr_req:  if (axi_grant) state <= st_wr_resp;
                st_wr_resp: begin
                    if (axil_req.bready) begin
                        state   <= st_idle;
                        aw_full <= 1'b0;
                        w_full  <= 1'b0;
                    end
                end
                st_rd_req:  if (axi_grant) state <= st_rd_wait;
                st_rd_wait: if (axi_rsp.valid) state <= st_rd_resp;
                st_rd_resp: begin
                    if (axil_req.rready) begin
                        state   <= st_idle;
                        ar_full <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // word address sits above the two byte-offset bits
    always_ff @(posedge clk) begin
        if (aw_hs) aw_addr_q <= axil_req.awaddr[`SPI_REGS_ADDR_W+1:2];
        if (ar_hs) ar_addr_q <= axil_req.araddr[`SPI_REGS_ADDR_W+1:2];
        if (w_hs) begin
            w_data_q  <= axil_req.wdata[`SPI_REGS_DATA_W-1:0];
            w_lane0_q <= axil_req.wstrb[0];
        end
        if (state == st_rd_wait && axi_rsp.valid) r_data_q <= axi_rsp.rdata;
    end

    // the request holds steady in its state until the bank grants it
    always_comb begin
        axi_req.valid = (state == st_wr_req) || (state == st_rd_req);
        axi_req.write = (state == st_wr_req);
        axi_req.addr  = (state == st_wr_req) ? aw_addr_q : ar_addr_q;
        axi_req.wdata = w_data_q;
    end

    always_comb begin
        axil_rsp.awready = aw_ready_q;
        axil_rsp.wready  = w_ready_q;
        axil_rsp.bvalid  = (state == st_wr_resp);
        axil_rsp.bresp   = 2'b00;
        axil_rsp.arready = ar_ready_q;
        axil_rsp.rvalid  = (state == st_rd_resp);
        axil_rsp.rdata   = {{(32 - `SPI_REGS_DATA_W){1'b0}}, r_data_q};
        axil_rsp.rresp   = 2'b00;
    end

endmodule

`default_nettype wire

//--- src/reg_bank.sv
// register storage shared by the SPI and AXI ports, SPI has fixed priority
// an AXI request waits as long as SPI requests keep arriving back to back
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module reg_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  spi_regs_pkg::reg_req_t spi_req,
    input  spi_regs_pkg::reg_req_t axi_req,
    output spi_regs_pkg::reg_rsp_t spi_rsp,
    output spi_regs_pkg::reg_rsp_t axi_rsp,
    output logic                   axi_grant
);
    import spi_regs_pkg::*;

    reg_req_t                    sel;
    logic [`SPI_REGS_DATA_W-1:0] regs [`SPI_REGS_COUNT];
    logic [`SPI_REGS_DATA_W-1:0] rd_data_q;
    logic                        spi_rd_q;
    logic                        axi_rd_q;

    // the MCU cannot be stalled, so the AXI side only gets idle SPI cycles
    assign axi_grant = !spi_req.valid;
    assign sel       = spi_req.valid ? spi_req : axi_req;

    // registers come up zeroed so reads after reset are defined
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SPI_REGS_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (sel.valid && sel.write) begin
            regs[sel.addr] <= sel.wdata;
        end
    end

    // the response flag follows the port that won this cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spi_rd_q <= 1'b0;
            axi_rd_q <= 1'b0;
        end else begin
            spi_rd_q <= spi_req.valid && !spi_req.write;
            axi_rd_q <= axi_grant && axi_req.valid && !axi_req.write;
        end
    end

    // only one read per cycle, so both ports share one data register
    always_ff @(posedge clk) begin
        if (sel.valid && !sel.write) begin
            rd_data_q <= regs[sel.addr];
        end
    end

    assign spi_rsp.valid = spi_rd_q;
    assign spi_rsp.rdata = rd_data_q;
    assign axi_rsp.valid = axi_rd_q;
    assign axi_rsp.rdata = rd_data_q;

endmodule

`default_nettype wire

//--- src/spi_reg_bridge_top.sv
// register bank reachable from an SPI mode 0 slave port and an AXI4-Lite slave port
// spi_clk must run at most at clk / 8
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bridge_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    spi_clk,
    input  logic                    spi_ss,
    input  logic                    spi_mosi,
    output logic                    spi_miso,
    input  spi_regs_pkg::axil_req_t axil_req,
    output spi_regs_pkg::axil_rsp_t axil_rsp
);
    import spi_regs_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       frame_start;
    logic [7:0] tx_byte;
    reg_req_t   spi_req;
    reg_rsp_t   spi_rsp;
    reg_req_t   axi_req;
    reg_rsp_t   axi_rsp;
    logic       axi_grant;

    // SPI pins to bytes
    spi_byte_slave spi_byte_slave_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .spi_clk     (spi_clk),
        .spi_ss      (spi_ss),
        .spi_mosi    (spi_mosi),
        .tx_byte     (tx_byte),
        .spi_miso    (spi_miso),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_start (frame_start)
    );

    // bytes to register requests
    spi_cmd_ctrl spi_cmd_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_start (frame_start),
        .spi_rsp     (spi_rsp),
        .tx_byte     (tx_byte),
        .spi_req     (spi_req)
    );

    axil_reg_port axil_reg_port_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil_req  (axil_req),
        .axi_rsp   (axi_rsp),
        .axi_grant (axi_grant),
        .axil_rsp  (axil_rsp),
        .axi_req   (axi_req)
    );

    reg_bank reg_bank_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .spi_req   (spi_req),
        .axi_req   (axi_req),
        .spi_rsp   (spi_rsp),
        .axi_rsp   (axi_rsp),
        .axi_grant (axi_grant)
    );

endmodule

`default_nettype wire

//--- sim/spi_reg_bridge_sva.sv
// assertions on bank arbitration and the AXI4-Lite response channels
// bound into the top level, where the reg_bank and axil_reg_port connections meet
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bridge_sva (
    input logic                    clk,
    input logic                    rst_n,
    input spi_regs_pkg::reg_req_t  spi_req,
    input spi_regs_pkg::reg_req_t  axi_req,
    input spi_regs_pkg::reg_rsp_t  spi_rsp,
    input spi_regs_pkg::reg_rsp_t  axi_rsp,
    input logic                    axi_grant,
    input logic [7:0]              tx_byte,
    input spi_regs_pkg::axil_req_t axil_req,
    input spi_regs_pkg::axil_rsp_t axil_rsp
);
    // SPI always wins the bank, and the AXI request waits unchanged for its turn
    grant_yields_to_spi: assert property (@(posedge clk) disable iff (!rst_n)
        spi_req.valid && axi_req.valid |-> !axi_grant ##1
            (axi_req.valid && $stable(axi_req.write) && $stable(axi_req.addr)))
        else $error("AXI request granted or dropped while an SPI request was served");

    // a write response waits for the master
    b_held: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    r_held: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    // read data comes one cycle after the request and is then kept for the shifter
    spi_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        spi_req.valid && !spi_req.write |=> spi_rsp.valid ##1
            (tx_byte == $past(spi_rsp.rdata)))
        else $error("spi_rsp late after an SPI read or its data not held in tx_byte");

    // the AXI side turns the bank response into rvalid one cycle later
    axi_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        axi_grant && axi_req.valid && !axi_req.write |=> axi_rsp.valid ##1 axil_rsp.rvalid)
        else $error("axi_rsp or rvalid late after a granted AXI read");

endmodule

bind spi_reg_bridge_top spi_reg_bridge_sva spi_reg_bridge_sva_inst (.*);

`default_nettype wire

//--- sim/tb_spi_reg_bridge.sv
// self-checking testbench for the SPI and AXI4-Lite register bridge
// SPI runs at 64 ns per bit, which is exactly the 8 clk minimum of the slave
// every task starts and ends on a falling clk edge
`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_cfg.svh"

module tb_spi_reg_bridge;
    import spi_regs_pkg::*;

    localparam int timeout_cycles = 4000;

    logic                        clk;
    logic                        rst_n;
    logic                        spi_clk;
    logic                        spi_ss;
    logic                        spi_mosi;
    logic                        spi_miso;
    axil_req_t                   axil_req;
    axil_rsp_t                   axil_rsp;
    logic [`SPI_REGS_DATA_W-1:0] ref_regs [`SPI_REGS_COUNT];
    integer                      seed;

    spi_reg_bridge_top spi_reg_bridge_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    // 8 ns clock period
    always #4 clk = ~clk;

    // the model holds what each register should contain after every completed write
    function automatic logic [`SPI_REGS_DATA_W-1:0] ref_read(
        input logic [`SPI_REGS_ADDR_W-1:0] addr
    );
        return ref_regs[addr];
    endfunction

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        stop_run();
    endtask

    task automatic report_mismatch(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
        stop_run();
    endtask

    task automatic check_byte(
        input string                       name,
        input logic [`SPI_REGS_DATA_W-1:0] got,
        input logic [`SPI_REGS_DATA_W-1:0] exp
    );
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    // only the fields of the channel that is currently valid are compared
    task automatic check_axil_rsp(input axil_rsp_t got, input axil_rsp_t exp);
        if (got.bvalid && got.bresp !== exp.bresp) begin
            report_mismatch("bresp", 32'(got.bresp), 32'(exp.bresp));
        end
        if (got.rvalid && got.rdata !== exp.rdata) begin
            report_mismatch("rdata", got.rdata, exp.rdata);
        end
        if (got.rvalid && got.rresp !== exp.rresp) begin
            report_mismatch("rresp", 32'(got.rresp), 32'(exp.rresp));
        end
    endtask

    // mode 0 master, data set while spi_clk is low and miso sampled on the rising edge
    task automatic spi_frame(
        input  logic [15:0] mosi_bits,
        input  int          nbits,
        output logic [15:0] miso_bits
    );
        miso_bits = '0;
        spi_ss    = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 15; i > 15 - nbits; i--) begin
            spi_mosi = mosi_bits[i];
            repeat (4) @(negedge clk);
            spi_clk      = 1'b1;
            miso_bits[i] = spi_miso;
            repeat (4) @(negedge clk);
            spi_clk = 1'b0;
        end
        repeat (4) @(negedge clk);
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        // gap so the slave sees spi_ss high before the next frame
        repeat (8) @(negedge clk);
    endtask

    task automatic spi_write(input logic [3:0] addr, input logic [7:0] data);
        logic [15:0] rx;
        spi_frame({4'h8, addr, data}, 16, rx);
        check_byte("spi_miso byte 1", rx[15:8], `SPI_REGS_IDLE_REPLY);
        // no read was issued, so byte 2 still carries the idle reply
        check_byte("spi_miso byte 2", rx[7:0], `SPI_REGS_IDLE_REPLY);
        ref_regs[addr] = data;
    endtask

    task automatic spi_read(input logic [3:0] addr);
        logic [15:0] rx;
        spi_frame({4'h0, addr, 8'h00}, 16, rx);
        check_byte("spi_miso byte 1", rx[15:8], `SPI_REGS_IDLE_REPLY);
        check_byte("spi_miso byte 2", rx[7:0], ref_read(addr));
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [7:0] data);
        axil_rsp_t exp;
        int        cnt;
        logic      aw_go;
        logic      w_go;
        exp               = '0;
        cnt               = 0;
        axil_req.awvalid  = 1'b1;
        axil_req.awaddr   = {26'd0, addr, 2'b00};
        axil_req.wvalid   = 1'b1;
        axil_req.wdata    = $random(seed);
        axil_req.wdata[7:0] = data;
        axil_req.wstrb    = 4'hf;
        // a ready seen at a falling edge completes its handshake at the next rising edge
        while (axil_req.awvalid || axil_req.wvalid) begin
            aw_go = axil_req.awvalid && axil_rsp.awready;
            w_go  = axil_req.wvalid && axil_rsp.wready;
            @(negedge clk);
            if (aw_go) axil_req.awvalid = 1'b0;
            if (w_go) axil_req.wvalid = 1'b0;
            cnt++;
            if (cnt > timeout_cycles) report_timeout("AXI write address and data handshakes");
        end
        cnt = 0;
        while (!axil_rsp.bvalid) begin
            @(negedge clk);
            cnt++;
            if (cnt > timeout_cycles) report_timeout("AXI write response");
        end
        check_axil_rsp(axil_rsp, exp);
        ref_regs[addr]  = data;
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr);
        axil_rsp_t exp;
        int        cnt;
        logic      ar_go;
        exp              = '0;
        cnt              = 0;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = {26'd0, addr, 2'b00};
        while (axil_req.arvalid) begin
            ar_go = axil_rsp.arready;
            @(negedge clk);
            if (ar_go) axil_req.arvalid = 1'b0;
            cnt++;
            if (cnt > timeout_cycles) report_timeout("AXI read address handshake");
        end
        cnt = 0;
        while (!axil_rsp.rvalid) begin
            @(negedge clk);
            cnt++;
            if (cnt > timeout_cycles) report_timeout("AXI read data");
        end
        // read data comes back zero-extended with an OKAY response
        exp.rdata = {24'd0, ref_read(addr)};
        check_axil_rsp(axil_rsp, exp);
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [3:0]  addr;
        logic [7:0]  data;
        logic [15:0] rx;
        logic [31:0] spi_rnd;
        logic [31:0] axi_rnd;
        logic        spi_done;
        int          axi_pairs;
        seed     = 32'hc5c6;
        clk      = 1'b0;
        rst_n    = 1'b0;
        spi_clk  = 1'b0;
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        axil_req = '0;
        for (int i = 0; i < `SPI_REGS_COUNT; i++) ref_regs[i] = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // every register reads zero out of reset
        for (int i = 0; i < `SPI_REGS_COUNT; i++) axi_read(i[3:0]);

        // SPI writes read back over AXI
        repeat (12) begin
            rnd  = $random(seed);
            addr = rnd[3:0];
            data = rnd[15:8];
            spi_write(addr, data);
            axi_read(addr);
        end

        // AXI writes read back over SPI
        repeat (12) begin
            rnd  = $random(seed);
            addr = rnd[3:0];
            data = rnd[15:8];
            axi_write(addr, data);
            spi_read(addr);
        end

        // a write frame cut off after 5 bits must leave the register alone
        rnd  = $random(seed);
        addr = rnd[3:0];
        data = ~ref_read(addr);
        spi_frame({4'h8, addr, data}, 5, rx);
        axi_read(addr);
        spi_read(addr);
        spi_write(addr, data);
        spi_read(addr);
        axi_read(addr);

        // SPI owns the lower half and AXI the upper half while both run at once
        // AXI keeps going for as long as SPI frames run, so some AXI requests meet SPI ones
        spi_done  = 1'b0;
        axi_pairs = 0;
        fork
            begin
                repeat (10) begin
                    spi_rnd = $random(seed);
                    spi_write({1'b0, spi_rnd[2:0]}, spi_rnd[15:8]);
                    spi_read({1'b0, spi_rnd[2:0]});
                end
                spi_done = 1'b1;
            end
            begin
                while (!spi_done) begin
                    axi_rnd = $random(seed);
                    axi_write({1'b1, axi_rnd[2:0]}, axi_rnd[15:8]);
                    axi_read({1'b1, axi_rnd[6:4]});
                    axi_pairs++;
                    if (axi_pairs > timeout_cycles) report_timeout("the SPI frames to finish");
                end
            end
        join

        // final sweep over writes from both ports
        for (int i = 0; i < `SPI_REGS_COUNT; i++) axi_read(i[3:0]);
        for (int i = 0; i < `SPI_REGS_COUNT; i++) spi_read(i[3:0]);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
src/spi_regs_pkg.sv
src/spi_byte_slave.sv
src/spi_cmd_ctrl.sv
src/axil_reg_port.sv
src/reg_bank.sv
src/spi_reg_bridge_top.sv
sim/spi_reg_bridge_sva.sv
sim/tb_spi_reg_bridge.sv

//--- Bender.yml
package:
  name: spi_reg_bridge

sources:
  - include_dirs:
      - src
    files:
      - src/spi_regs_pkg.sv
      - src/spi_byte_slave.sv
      - src/spi_cmd_ctrl.sv
      - src/axil_reg_port.sv
      - src/reg_bank.sv
      - src/spi_reg_bridge_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/spi_reg_bridge_sva.sv
      - sim/tb_spi_reg_bridge.sv
